//--- hw/fixed_format_pkg.sv
// Fixed-point number formats for scores, slopes, intercepts, exponents and row sums
package fixed_format_pkg;

    // Score x, signed Q4.4, integer part limited to -8..0
    localparam int in_width = 8;
    localparam int in_frac_width = 4;
    localparam int int_width = in_width - in_frac_width;

    // Exponent result, unsigned Q4.4
    localparam int exp_width = 8;
    localparam int exp_frac_width = 4;

    // Chord slope, truncated, two integer bits
    localparam int slope_frac_width = 8;
    localparam int slope_width = slope_frac_width + 2;

    // Fraction times slope
    localparam int mult_width = in_width + slope_width;
    localparam int mult_frac_width = in_frac_width + slope_frac_width;

    // Intercept is aligned to the product's fraction
    localparam int intercept_frac_width = mult_frac_width;
    localparam int intercept_width = intercept_frac_width + 2;

    // Product plus intercept, one carry bit over the product
    localparam int lpw_width = mult_width + 1;
    localparam int lpw_frac_width = mult_frac_width;

    // Row sum, unsigned Q12.4, wraps on overflow
    localparam int sum_width = 16;

endpackage

//--- hw/softermax_stream_pkg.sv
// Stream payloads: input score, exponent beat and row output with sum
package softermax_stream_pkg;

    import fixed_format_pkg::*;

    // Offset score entering the exponent stage
    typedef struct packed {
        logic [in_width-1:0] x;
        logic                last;
    } score_t;

    // Exponent from the pow2 block to the accumulator
    typedef struct packed {
        logic [exp_width-1:0] value;
        logic                 last;
    } exp_beat_t;

    // Output beat, sum only meaningful with last set
    typedef struct packed {
        logic [exp_width-1:0] value;
        logic                 last;
        logic [sum_width-1:0] sum;
    } row_out_t;

endpackage

//--- hw/skid_buffer.sv
// skid_buffer: two-entry valid/ready register slice with registered ready
module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     out_free;
    logic     accept;

    // Main register can be loaded this cycle
    assign out_free = out_ready || !out_valid;

    // Ready comes straight from state, cutting the backward path
    assign in_ready = !skid_valid;
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // Drain the skid entry first to keep order
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        // Output stalled, park the incoming beat
        if (!out_free && accept) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- hw/fixed_signed_cast.sv
// fixed_signed_cast: floor and saturate from the wide LPW format to the exponent format
module fixed_signed_cast (
    input  logic [fixed_format_pkg::lpw_width:0]   in_data,
    output logic [fixed_format_pkg::exp_width-1:0] out_data
);

    import fixed_format_pkg::*;

    logic signed [lpw_width:0] floored;

    // Arithmetic shift drops the extra fraction bits, rounding toward minus infinity
    assign floored = $signed(in_data) >>> (lpw_frac_width - exp_frac_width);

    always_comb begin
        if (floored[lpw_width]) begin
            // Below the unsigned range
            out_data = '0;
        end else if (|floored[lpw_width-1:exp_width]) begin
            // Clamp to the largest code
            out_data = '1;
        end else begin
            out_data = floored[exp_width-1:0];
        end
    end

endmodule

//--- hw/softermax_lpw_pow2.sv
// softermax_lpw_pow2: four-piece linear 2^x with a right shift by the integer part
module softermax_lpw_pow2 (
    input  logic                              clk,
    input  logic                              reset,

    input  softermax_stream_pkg::score_t      in_data,
    input  logic                              in_valid,
    output logic                              in_ready,

    output softermax_stream_pkg::exp_beat_t   out_data,
    output logic                              out_valid,
    input  logic                              out_ready
);

    import fixed_format_pkg::*;
    import softermax_stream_pkg::*;

    typedef struct packed {
        logic [int_width-1:0]  shift;
        logic [1:0]            sel;
        logic [mult_width-1:0] mult;
        logic                  last;
    } mult_stage_t;

    // Shift holds the right shift still to be applied
    typedef struct packed {
        logic [int_width-1:0] shift;
        logic [lpw_width-1:0] lpw;
        logic                 last;
    } shift_stage_t;

    // Chord slope between 2^(s/4) and 2^((s+1)/4), truncated
    function automatic logic [slope_width-1:0] slope_at(int s);
        real x1;
        real x2;
        real m;
        x1 = s / 4.0;
        x2 = (s + 1) / 4.0;
        m = (2.0 ** x2 - 2.0 ** x1) / (x2 - x1);
        return slope_width'($rtoi(m * 2.0 ** slope_frac_width));
    endfunction

    // Intercept of the same chord at f = 0, truncated
    function automatic logic [intercept_width-1:0] intercept_at(int s);
        real x1;
        real x2;
        real m;
        real c;
        x1 = s / 4.0;
        x2 = (s + 1) / 4.0;
        m = (2.0 ** x2 - 2.0 ** x1) / (x2 - x1);
        c = 2.0 ** x1 - m * x1;
        return intercept_width'($rtoi(c * 2.0 ** intercept_frac_width));
    endfunction

    localparam logic [3:0][slope_width-1:0] slope_table =
        {slope_at(3), slope_at(2), slope_at(1), slope_at(0)};
    localparam logic [3:0][intercept_width-1:0] intercept_table =
        {intercept_at(3), intercept_at(2), intercept_at(1), intercept_at(0)};

    logic [int_width-1:0]     x_int;
    logic [in_frac_width-1:0] x_frac;
    logic [1:0]               x_sel;

    mult_stage_t  mult_d, mult_q;
    logic         mult_valid, mult_ready;
    shift_stage_t icpt_d, icpt_q;
    logic         icpt_valid, icpt_ready;
    shift_stage_t shift_d, shift_q;
    logic         shift_valid, shift_ready;
    logic [exp_width-1:0] cast_out;
    exp_beat_t    result_d;

    assign x_int = in_data.x[in_width-1:in_frac_width];
    assign x_frac = in_data.x[in_frac_width-1:0];
    // Top fraction bits pick the piece
    assign x_sel = x_frac[in_frac_width-1 -: 2];

    // Stage 1: fraction times slope
    always_comb begin
        mult_d.shift = -x_int;
        mult_d.sel = x_sel;
        mult_d.mult = mult_width'(x_frac) * mult_width'(slope_table[x_sel]);
        mult_d.last = in_data.last;
    end

    skid_buffer #(.payload_t(mult_stage_t)) mult_reg (
        .clk(clk), .reset(reset),
        .in_data(mult_d), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(mult_q), .out_valid(mult_valid), .out_ready(mult_ready)
    );

    // Stage 2: add intercept, result lies in [1, 2)
    always_comb begin
        icpt_d.shift = mult_q.shift;
        icpt_d.lpw = lpw_width'(mult_q.mult) + lpw_width'(intercept_table[mult_q.sel]);
        icpt_d.last = mult_q.last;
    end

    skid_buffer #(.payload_t(shift_stage_t)) intercept_reg (
        .clk(clk), .reset(reset),
        .in_data(icpt_d), .in_valid(mult_valid), .in_ready(mult_ready),
        .out_data(icpt_q), .out_valid(icpt_valid), .out_ready(icpt_ready)
    );

    // Stage 3: scale down by the integer part
    always_comb begin
        shift_d.shift = '0;
        shift_d.lpw = icpt_q.lpw >> icpt_q.shift;
        shift_d.last = icpt_q.last;
    end

    skid_buffer #(.payload_t(shift_stage_t)) shift_reg (
        .clk(clk), .reset(reset),
        .in_data(shift_d), .in_valid(icpt_valid), .in_ready(icpt_ready),
        .out_data(shift_q), .out_valid(shift_valid), .out_ready(shift_ready)
    );

    fixed_signed_cast lpw_cast (
        .in_data({1'b0, shift_q.lpw}),
        .out_data(cast_out)
    );

    assign result_d.value = cast_out;
    assign result_d.last = shift_q.last;

    // Stage 4: output register
    skid_buffer #(.payload_t(exp_beat_t)) out_reg (
        .clk(clk), .reset(reset),
        .in_data(result_d), .in_valid(shift_valid), .in_ready(shift_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

//--- hw/softermax_row_accum.sv
// softermax_row_accum: forwards exponents and attaches the running row sum
module softermax_row_accum (
    input  logic                              clk,
    input  logic                              reset,

    input  softermax_stream_pkg::exp_beat_t   in_data,
    input  logic                              in_valid,
    output logic                              in_ready,

    output softermax_stream_pkg::row_out_t    out_data,
    output logic                              out_valid,
    input  logic                              out_ready
);

    import fixed_format_pkg::*;
    import softermax_stream_pkg::*;

    logic [sum_width-1:0] row_sum;
    row_out_t             out_d;
    logic                 accept;

    assign accept = in_valid && in_ready;

    // Sum includes the current beat
    always_comb begin
        out_d.value = in_data.value;
        out_d.last = in_data.last;
        out_d.sum = row_sum + sum_width'(in_data.value);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row_sum <= '0;
        end else if (accept) begin
            // New row starts after the last beat
            row_sum <= in_data.last ? '0 : out_d.sum;
        end
    end

    skid_buffer #(.payload_t(row_out_t)) out_reg (
        .clk(clk),
        .reset(reset),
        .in_data(out_d),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- hw/softermax_pow2_row.sv
// softermax_pow2_row: top level with the pow2 exponent block and the row accumulator
module softermax_pow2_row (
    input  logic                              clk,
    input  logic                              reset,

    input  softermax_stream_pkg::score_t      in_data,
    input  logic                              in_valid,
    output logic                              in_ready,

    output softermax_stream_pkg::row_out_t    out_data,
    output logic                              out_valid,
    input  logic                              out_ready
);

    import softermax_stream_pkg::*;

    exp_beat_t exp_data;
    logic      exp_valid;
    logic      exp_ready;

    softermax_lpw_pow2 pow2_i (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(exp_data),
        .out_valid(exp_valid),
        .out_ready(exp_ready)
    );

    softermax_row_accum accum_i (
        .clk(clk),
        .reset(reset),
        .in_data(exp_data),
        .in_valid(exp_valid),
        .in_ready(exp_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- dv/softermax_pow2_row_properties.sv
// Reference FIFO of accepted scores and concurrent checks on the row output stream
module softermax_pow2_row_properties (
    input logic                           clk,
    input logic                           reset,
    input softermax_stream_pkg::score_t   in_data,
    input logic                           in_valid,
    input logic                           in_ready,
    input softermax_stream_pkg::row_out_t out_data,
    input logic                           out_valid,
    input logic                           out_ready
);

    import fixed_format_pkg::*;
    import softermax_stream_pkg::*;

    localparam int ref_depth = 64;

    score_t               ref_mem [ref_depth];
    logic [5:0]           wr_ptr;
    logic [5:0]           rd_ptr;
    score_t               head;
    logic                 in_fire;
    logic                 out_fire;
    logic                 after_reset;
    logic                 hold_pending;
    row_out_t             held_data;
    logic [sum_width-1:0] obs_sum;
    logic [sum_width-1:0] expected_sum;
    logic [4:0]           accept_hist;
    int                   ready_run;
    real                  ideal;
    real                  diff;
    logic                 value_ok;
    int                   fail_count = 0;

    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // Ideal 2^x in exponent LSBs for the oldest pending score
    always_comb begin
        head = ref_mem[rd_ptr];
        ideal = 16.0 * (2.0 ** ($itor($signed(head.x)) / 16.0));
        diff = $itor(out_data.value) - ideal;
        if (head.x == 8'h80) begin
            value_ok = out_data.value <= 8'd1;
        end else begin
            value_ok = (diff < 2.0) && (diff > -2.0);
        end
        expected_sum = obs_sum + sum_width'(out_data.value);
    end

    always_ff @(posedge clk) begin
        after_reset <= reset;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            obs_sum      <= '0;
            hold_pending <= 1'b0;
            accept_hist  <= '0;
            ready_run    <= 0;
        end else begin
            if (in_fire) begin
                ref_mem[wr_ptr] <= in_data;
                wr_ptr <= wr_ptr + 6'd1;
            end
            if (out_fire) begin
                rd_ptr <= rd_ptr + 6'd1;
                obs_sum <= out_data.last ? '0 : expected_sum;
            end
            hold_pending <= out_valid && !out_ready;
            held_data    <= out_data;
            accept_hist  <= {accept_hist[3:0], in_fire};
            // Consecutive edges with the sink ready, so every skid entry has drained
            ready_run    <= out_ready ? ready_run + 1 : 0;
        end
    end

    assert property (@(posedge clk) after_reset |-> !out_valid)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_valid got %0b expected 0", $time, out_valid);
        end

    assert property (@(posedge clk) after_reset |-> in_ready)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t in_ready got %0b expected 1", $time, in_ready);
        end

    assert property (@(posedge clk) disable iff (reset)
        hold_pending |-> (out_valid && out_data == held_data))
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_data got %h/%0b expected %h/1 while stalled",
                $time, out_data, out_valid, held_data);
        end

    assert property (@(posedge clk) disable iff (reset) out_fire |-> wr_ptr != rd_ptr)
        else begin
            fail_count = fail_count + 1;
            $error("Output beat at time %0t arrived with no score pending", $time);
        end

    assert property (@(posedge clk) disable iff (reset) out_fire |-> value_ok)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_data.value got %0d expected %0.2f (x=%0d/16)",
                $time, out_data.value, ideal, $signed(head.x));
        end

    assert property (@(posedge clk) disable iff (reset) out_fire |-> out_data.last == head.last)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_data.last got %0b expected %0b",
                $time, out_data.last, head.last);
        end

    assert property (@(posedge clk) disable iff (reset)
        (out_fire && out_data.last) |-> out_data.sum == expected_sum)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_data.sum got %0d expected %0d",
                $time, out_data.sum, expected_sum);
        end

    // Five edges from input accept to output transfer on a free-flowing pipe
    assert property (@(posedge clk) disable iff (reset)
        (accept_hist[4] && ready_run >= 12) |-> out_valid)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH time=%0t out_valid got %0b expected 1 five edges after accept",
                $time, out_valid);
        end

endmodule

//--- dv/softermax_pow2_row_tb.sv
// Testbench for the softermax pow2 row stage: clock, reset, random stimulus, timeout, report
module softermax_pow2_row_tb;

    import softermax_stream_pkg::*;

    localparam int num_scores = 300;
    localparam int full_speed_count = 60;
    // Sink stays ready a while after inputs start to idle
    localparam int ready_hold_count = 90;
    localparam int stall_at = 150;
    localparam int stall_cycles = 20;
    localparam int timeout_cycles = num_scores * 4 + 200;

    logic     clk = 1'b0;
    logic     reset;
    score_t   in_data;
    logic     in_valid;
    logic     in_ready;
    row_out_t out_data;
    logic     out_valid;
    logic     out_ready;

    integer   seed;
    int       row_left;
    int       sent;
    int       results_seen;
    int       cycle_count;

    softermax_pow2_row softermax_pow2_row_i (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    bind softermax_pow2_row softermax_pow2_row_properties props_i (.*);

    always #50 clk = ~clk;

    // Score with int part in -8..0 and a random fraction, rows of 1 to 8 beats
    task automatic draw_score(input logic force_last, output score_t s);
        int mag;
        int frac;
        mag = {$random(seed)} % 9;
        frac = {$random(seed)} % 16;
        if (row_left == 0) begin
            row_left = 1 + ({$random(seed)} % 8);
        end
        row_left = row_left - 1;
        s.x = {4'(-mag), 4'(frac)};
        s.last = (row_left == 0) || force_last;
    endtask

    task automatic print_summary(input int timeouts);
        $display("Summary: %0d assertion failures, %0d timeouts, %0d of %0d results received",
            softermax_pow2_row_i.props_i.fail_count, timeouts, results_seen, num_scores);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= timeout_cycles) begin
                $display("Timeout after %0d cycles, results still missing", cycle_count);
                print_summary(1);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin : stimulus
        score_t next;
        logic   fire_pending;
        logic   stall_done;
        int     stall_left;
        seed = 32'h67ff_ebde;
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        row_left = 0;
        sent = 0;
        results_seen = 0;
        cycle_count = 0;
        fire_pending = 1'b0;
        stall_done = 1'b0;
        stall_left = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (results_seen < num_scores) begin
            // Beat handed over on the rising edge just passed
            if (fire_pending) begin
                in_valid = 1'b0;
                sent = sent + 1;
            end
            if (!in_valid && sent < num_scores &&
                (sent < full_speed_count || ({$random(seed)} % 4) != 0)) begin
                draw_score(sent == num_scores - 1, next);
                in_data = next;
                in_valid = 1'b1;
            end
            // in_ready holds until the next rising edge
            fire_pending = in_valid && in_ready;

            if (stall_left > 0) begin
                out_ready = 1'b0;
                stall_left = stall_left - 1;
            end else if (sent < ready_hold_count) begin
                out_ready = 1'b1;
            end else begin
                out_ready = ({$random(seed)} % 4) != 0;
            end
            if (out_valid && out_ready) begin
                results_seen = results_seen + 1;
            end
            if (sent == stall_at && !stall_done) begin
                stall_left = stall_cycles;
                stall_done = 1'b1;
            end
            @(negedge clk);
        end

        // Let the last transfer and its checks complete
        repeat (3) @(negedge clk);
        print_summary(0);
        if (softermax_pow2_row_i.props_i.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/fixed_format_pkg.sv
hw/softermax_stream_pkg.sv
hw/skid_buffer.sv
hw/fixed_signed_cast.sv
hw/softermax_lpw_pow2.sv
hw/softermax_row_accum.sv
hw/softermax_pow2_row.sv
dv/softermax_pow2_row_properties.sv
dv/softermax_pow2_row_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module softermax_pow2_row_tb -f sim.f -Mdir obj_dir

output=$(./obj_dir/Vsoftermax_pow2_row_tb +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -qx 'Test passed' <<< "$output"; then
    exit 0
fi
exit 1
